// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_commit_core
FILELIST := all.f
OBJDIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf $(OBJDIR)

// ==== all.f ====
rtl/commit_pkg.sv
rtl/commit_ctrl.sv
rtl/csr_file.sv
rtl/wb_stage.sv
rtl/regfile.sv
rtl/commit_core.sv
tests/tb_commit_core.sv

// ==== rtl/commit_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module commit_core #(
    parameter int NUM_REGS = 32,
    parameter int NUM_SAVE = 4
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire commit_pkg::commit_lane_t     i_lane_a,
    input  wire commit_pkg::commit_lane_t     i_lane_b,
    input  wire [commit_pkg::REG_ADDR_W-1:0]  i_rf_raddr1,
    input  wire [commit_pkg::REG_ADDR_W-1:0]  i_rf_raddr2,
    output logic [commit_pkg::XLEN-1:0]       o_rf_rdata1,
    output logic [commit_pkg::XLEN-1:0]       o_rf_rdata2,
    output logic                              o_flush,
    output logic [commit_pkg::XLEN-1:0]       o_redirect_pc,
    output logic                              o_dbg_a_wen,
    output logic [commit_pkg::XLEN-1:0]       o_dbg_a_pc,
    output logic [commit_pkg::REG_ADDR_W-1:0] o_dbg_a_wnum,
    output logic [commit_pkg::XLEN-1:0]       o_dbg_a_wdata,
    output logic                              o_dbg_b_wen,
    output logic [commit_pkg::XLEN-1:0]       o_dbg_b_pc,
    output logic [commit_pkg::REG_ADDR_W-1:0] o_dbg_b_wnum,
    output logic [commit_pkg::XLEN-1:0]       o_dbg_b_wdata
);
    import commit_pkg::*;

    csr_cmd_t              csr_cmd;
    wb_ctrl_t              wb_ctrl;
    logic [XLEN-1:0]       csr_rdata;
    logic [XLEN-1:0]       era;
    logic [XLEN-1:0]       eentry;
    logic                  rf_we1;
    logic [REG_ADDR_W-1:0] rf_waddr1;
    logic [XLEN-1:0]       rf_wdata1;
    logic                  rf_we2;
    logic [REG_ADDR_W-1:0] rf_waddr2;
    logic [XLEN-1:0]       rf_wdata2;

    commit_ctrl u_commit_ctrl (
        .i_lane_a      (i_lane_a),
        .i_lane_b      (i_lane_b),
        .i_era         (era),
        .i_eentry      (eentry),
        .o_csr_cmd     (csr_cmd),
        .o_wb_ctrl     (wb_ctrl),
        .o_flush       (o_flush),
        .o_redirect_pc (o_redirect_pc)
    );

    csr_file #(.NUM_SAVE(NUM_SAVE)) u_csr_file (
        .clk         (clk),
        .reset       (reset),
        .i_cmd       (csr_cmd),
        .o_csr_rdata (csr_rdata),
        .o_era       (era),
        .o_eentry    (eentry)
    );

    wb_stage u_wb_stage (
        .clk           (clk),
        .reset         (reset),
        .i_lane_a      (i_lane_a),
        .i_lane_b      (i_lane_b),
        .i_wb_ctrl     (wb_ctrl),
        .i_csr_rdata   (csr_rdata),
        .o_rf_we1      (rf_we1),
        .o_rf_waddr1   (rf_waddr1),
        .o_rf_wdata1   (rf_wdata1),
        .o_rf_we2      (rf_we2),
        .o_rf_waddr2   (rf_waddr2),
        .o_rf_wdata2   (rf_wdata2),
        .o_dbg_a_wen   (o_dbg_a_wen),
        .o_dbg_a_pc    (o_dbg_a_pc),
        .o_dbg_a_wnum  (o_dbg_a_wnum),
        .o_dbg_a_wdata (o_dbg_a_wdata),
        .o_dbg_b_wen   (o_dbg_b_wen),
        .o_dbg_b_pc    (o_dbg_b_pc),
        .o_dbg_b_wnum  (o_dbg_b_wnum),
        .o_dbg_b_wdata (o_dbg_b_wdata)
    );

    regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
        .clk      (clk),
        .i_we1    (rf_we1),
        .i_waddr1 (rf_waddr1),
        .i_wdata1 (rf_wdata1),
        .i_we2    (rf_we2),
        .i_waddr2 (rf_waddr2),
        .i_wdata2 (rf_wdata2),
        .i_raddr1 (i_rf_raddr1),
        .i_raddr2 (i_rf_raddr2),
        .o_rdata1 (o_rf_rdata1),
        .o_rdata2 (o_rf_rdata2)
    );

endmodule

`default_nettype wire

// ==== rtl/commit_ctrl.sv ====
`default_nettype none
`timescale 1ns/100ps

module commit_ctrl (
    input  wire commit_pkg::commit_lane_t i_lane_a,
    input  wire commit_pkg::commit_lane_t i_lane_b,
    input  wire [commit_pkg::XLEN-1:0]    i_era,
    input  wire [commit_pkg::XLEN-1:0]    i_eentry,
    output commit_pkg::csr_cmd_t          o_csr_cmd,
    output commit_pkg::wb_ctrl_t          o_wb_ctrl,
    output logic                          o_flush,
    output logic [commit_pkg::XLEN-1:0]   o_redirect_pc
);
    import commit_pkg::*;

    logic         a_exc;
    logic         b_exc;
    logic         a_ertn;
    logic         b_ertn;
    logic         a_commit;
    logic         b_commit;
    logic         exc_from_b;
    logic         exc_take;
    logic         ertn_take;
    logic         csr_from_a;
    logic         csr_do;
    commit_lane_t exc_lane;
    commit_lane_t csr_lane;

    // ERTN travels as an exception type but retires like a normal instruction.
    assign a_exc  = i_lane_a.valid && i_lane_a.has_exc && i_lane_a.exc_type != ERTN;
    assign b_exc  = i_lane_b.valid && i_lane_b.has_exc && i_lane_b.exc_type != ERTN;
    assign a_ertn = i_lane_a.valid && i_lane_a.has_exc && i_lane_a.exc_type == ERTN;
    assign b_ertn = i_lane_b.valid && i_lane_b.has_exc && i_lane_b.exc_type == ERTN;

    assign a_commit = i_lane_a.valid && !a_exc;
    assign b_commit = i_lane_b.valid && !b_exc && !a_exc; // Older exception squashes b.

    assign exc_from_b = !a_exc && b_exc;
    assign exc_take   = a_exc || exc_from_b;
    assign exc_lane   = exc_from_b ? i_lane_b : i_lane_a;
    assign ertn_take  = !exc_take && (a_ertn || b_ertn);

    // At most one lane carries a CSR operation, lane a is checked first.
    assign csr_from_a = i_lane_a.valid && i_lane_a.is_csr;
    assign csr_lane   = csr_from_a ? i_lane_a : i_lane_b;
    assign csr_do     = !exc_take && (csr_from_a || (i_lane_b.valid && i_lane_b.is_csr));

    always_comb begin
        o_csr_cmd.we       = csr_do;
        o_csr_cmd.addr     = csr_lane.csr_addr;
        o_csr_cmd.mask     = csr_lane.csr_mask;
        o_csr_cmd.wdata    = csr_lane.result;
        o_csr_cmd.exc_take = exc_take;
        o_csr_cmd.exc_type = exc_lane.exc_type;
        o_csr_cmd.exc_pc   = exc_lane.pc;
        // A fetch fault reports its own PC, a misaligned access its data address.
        o_csr_cmd.exc_badv = (exc_lane.exc_type == ADEF) ? exc_lane.pc : exc_lane.result;
        o_csr_cmd.ertn     = ertn_take;
    end

    always_comb begin
        o_wb_ctrl.a_commit  = a_commit;
        o_wb_ctrl.b_commit  = b_commit;
        o_wb_ctrl.a_use_csr = csr_do && csr_from_a;
        o_wb_ctrl.b_use_csr = csr_do && !csr_from_a;
    end

    assign o_flush = exc_take || ertn_take || csr_do;

    always_comb begin
        if (exc_take) begin
            o_redirect_pc = i_eentry;
        end else if (ertn_take) begin
            o_redirect_pc = i_era;
        end else begin
            o_redirect_pc = csr_lane.pc + XLEN'(4); // Refetch after the CSR access.
        end
    end

endmodule

`default_nettype wire

// ==== rtl/commit_pkg.sv ====
`default_nettype none

package commit_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 14;
    localparam int ECODE_W    = 6;

    // Each exception kind is encoded as its architectural ecode.
    typedef enum logic [ECODE_W-1:0] {
        INT  = 6'h00,
        ADEF = 6'h08,
        ALE  = 6'h09,
        SYS  = 6'h0b,
        BRK  = 6'h0c,
        INE  = 6'h0d,
        ERTN = 6'h3f   // A return, it never enters the handler.
    } exc_type_e;

    typedef enum logic [CSR_ADDR_W-1:0] {
        CRMD   = 14'd0,
        PRMD   = 14'd1,
        ESTAT  = 14'd5,
        ERA    = 14'd6,
        BADV   = 14'd7,
        EENTRY = 14'd12,
        SAVE0  = 14'd48,
        SAVE1  = 14'd49,
        SAVE2  = 14'd50,
        SAVE3  = 14'd51
    } csr_addr_e;

    // One completed instruction as it arrives at retirement.
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       result;     // ALU result, ALE address or CSR write data.
        logic [REG_ADDR_W-1:0] dest;
        logic                  has_exc;
        exc_type_e             exc_type;
        logic                  is_csr;
        csr_addr_e             csr_addr;
        logic [XLEN-1:0]       csr_mask;
    } commit_lane_t;

    typedef struct packed {
        logic            we;
        csr_addr_e       addr;
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] wdata;
        logic            exc_take;
        exc_type_e       exc_type;
        logic [XLEN-1:0] exc_pc;
        logic [XLEN-1:0] exc_badv;
        logic            ertn;
    } csr_cmd_t;

    typedef struct packed {
        logic a_commit;
        logic b_commit;
        logic a_use_csr;
        logic b_use_csr;
    } wb_ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/csr_file.sv ====
`default_nettype none
`timescale 1ns/100ps

module csr_file #(
    parameter int NUM_SAVE = 4
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire commit_pkg::csr_cmd_t   i_cmd,
    output logic [commit_pkg::XLEN-1:0] o_csr_rdata,
    output logic [commit_pkg::XLEN-1:0] o_era,
    output logic [commit_pkg::XLEN-1:0] o_eentry
);
    import commit_pkg::*;

    localparam int SAVE_IDX_W = (NUM_SAVE > 1) ? $clog2(NUM_SAVE) : 1;

    logic [1:0]            crmd_plv;
    logic                  crmd_ie;
    logic [1:0]            prmd_pplv;
    logic                  prmd_pie;
    logic [ECODE_W-1:0]    estat_ecode;
    logic [XLEN-1:0]       era;
    logic [XLEN-1:0]       badv;
    logic [XLEN-1:6]       eentry_va;
    logic [XLEN-1:0]       save [NUM_SAVE];

    logic                  save_hit;
    logic [SAVE_IDX_W-1:0] save_idx;
    logic [XLEN-1:0]       wval;

    assign save_hit = (i_cmd.addr >= SAVE0) &&
                      (i_cmd.addr < CSR_ADDR_W'(SAVE0 + NUM_SAVE));
    assign save_idx = SAVE_IDX_W'(i_cmd.addr - SAVE0);

    always_comb begin
        o_csr_rdata = '0;
        case (i_cmd.addr)
            CRMD:   o_csr_rdata = XLEN'({crmd_ie, crmd_plv});
            PRMD:   o_csr_rdata = XLEN'({prmd_pie, prmd_pplv});
            ESTAT:  o_csr_rdata = XLEN'({estat_ecode, 16'd0}); // Ecode sits in bits 21:16.
            ERA:    o_csr_rdata = era;
            BADV:   o_csr_rdata = badv;
            EENTRY: o_csr_rdata = {eentry_va, 6'd0};
            default: begin
                if (save_hit) begin
                    o_csr_rdata = save[save_idx];
                end
            end
        endcase
    end

    // Only the masked bits take the new value.
    assign wval = (o_csr_rdata & ~i_cmd.mask) | (i_cmd.wdata & i_cmd.mask);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv    <= 2'd0;
            crmd_ie     <= 1'b0;
            prmd_pplv   <= 2'd0;
            prmd_pie    <= 1'b0;
            estat_ecode <= '0;
            eentry_va   <= '0;
        end else if (i_cmd.exc_take) begin
            // Enter the handler at kernel level with interrupts off.
            prmd_pplv   <= crmd_plv;
            prmd_pie    <= crmd_ie;
            crmd_plv    <= 2'd0;
            crmd_ie     <= 1'b0;
            estat_ecode <= i_cmd.exc_type;
        end else if (i_cmd.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (i_cmd.we) begin
            case (i_cmd.addr)
                CRMD: begin
                    crmd_plv <= wval[1:0];
                    crmd_ie  <= wval[2];
                end
                PRMD: begin
                    prmd_pplv <= wval[1:0];
                    prmd_pie  <= wval[2];
                end
                EENTRY:  eentry_va <= wval[XLEN-1:6];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_cmd.exc_take) begin
            era <= i_cmd.exc_pc;
            if (i_cmd.exc_type == ALE || i_cmd.exc_type == ADEF) begin
                badv <= i_cmd.exc_badv;
            end
        end else if (i_cmd.we && !i_cmd.ertn) begin
            case (i_cmd.addr)
                ERA:  era <= wval;
                BADV: badv <= wval;
                default: begin
                    if (save_hit) begin
                        save[save_idx] <= wval;
                    end
                end
            endcase
        end
    end

    assign o_era    = era;
    assign o_eentry = {eentry_va, 6'd0};   // Handler entry is 64-byte aligned.

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
`default_nettype none
`timescale 1ns/100ps

module regfile #(
    parameter int NUM_REGS = 32
) (
    input  wire                               clk,
    input  wire                               i_we1,
    input  wire [commit_pkg::REG_ADDR_W-1:0]  i_waddr1,
    input  wire [commit_pkg::XLEN-1:0]        i_wdata1,
    input  wire                               i_we2,
    input  wire [commit_pkg::REG_ADDR_W-1:0]  i_waddr2,
    input  wire [commit_pkg::XLEN-1:0]        i_wdata2,
    input  wire [commit_pkg::REG_ADDR_W-1:0]  i_raddr1,
    input  wire [commit_pkg::REG_ADDR_W-1:0]  i_raddr2,
    output logic [commit_pkg::XLEN-1:0]       o_rdata1,
    output logic [commit_pkg::XLEN-1:0]       o_rdata2
);
    import commit_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // Port 2 carries the younger lane, so its write lands last.
    always_ff @(posedge clk) begin
        if (i_we1) begin
            regs[i_waddr1] <= i_wdata1;
        end
        if (i_we2) begin
            regs[i_waddr2] <= i_wdata2;
        end
    end

    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

// ==== rtl/wb_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module wb_stage (
    input  wire                               clk,
    input  wire                               reset,
    input  wire commit_pkg::commit_lane_t     i_lane_a,
    input  wire commit_pkg::commit_lane_t     i_lane_b,
    input  wire commit_pkg::wb_ctrl_t         i_wb_ctrl,
    input  wire [commit_pkg::XLEN-1:0]        i_csr_rdata,
    output logic                              o_rf_we1,
    output logic [commit_pkg::REG_ADDR_W-1:0] o_rf_waddr1,
    output logic [commit_pkg::XLEN-1:0]       o_rf_wdata1,
    output logic                              o_rf_we2,
    output logic [commit_pkg::REG_ADDR_W-1:0] o_rf_waddr2,
    output logic [commit_pkg::XLEN-1:0]       o_rf_wdata2,
    output logic                              o_dbg_a_wen,
    output logic [commit_pkg::XLEN-1:0]       o_dbg_a_pc,
    output logic [commit_pkg::REG_ADDR_W-1:0] o_dbg_a_wnum,
    output logic [commit_pkg::XLEN-1:0]       o_dbg_a_wdata,
    output logic                              o_dbg_b_wen,
    output logic [commit_pkg::XLEN-1:0]       o_dbg_b_pc,
    output logic [commit_pkg::REG_ADDR_W-1:0] o_dbg_b_wnum,
    output logic [commit_pkg::XLEN-1:0]       o_dbg_b_wdata
);
    import commit_pkg::*;

    commit_lane_t          lane      [2];
    logic                  commit    [2];
    logic                  use_csr   [2];
    logic                  wb_valid  [2];
    logic [XLEN-1:0]       wb_pc     [2];
    logic [REG_ADDR_W-1:0] wb_dest   [2];
    logic [XLEN-1:0]       wb_data   [2];
    logic                  dbg_wen   [2];
    logic [XLEN-1:0]       dbg_pc    [2];
    logic [REG_ADDR_W-1:0] dbg_wnum  [2];
    logic [XLEN-1:0]       dbg_wdata [2];

    assign lane[0]    = i_lane_a;
    assign lane[1]    = i_lane_b;
    assign commit[0]  = i_wb_ctrl.a_commit;
    assign commit[1]  = i_wb_ctrl.b_commit;
    assign use_csr[0] = i_wb_ctrl.a_use_csr;
    assign use_csr[1] = i_wb_ctrl.b_use_csr;

    for (genvar i = 0; i < 2; i++) begin : g_lane
        always_ff @(posedge clk) begin
            if (reset) begin
                wb_valid[i] <= 1'b0;
                dbg_wen[i]  <= 1'b0;
            end else begin
                wb_valid[i] <= commit[i];
                dbg_wen[i]  <= wb_valid[i] && wb_dest[i] != '0; // r0 is never reported.
            end
        end

        always_ff @(posedge clk) begin
            if (commit[i]) begin
                wb_pc[i]   <= lane[i].pc;
                wb_dest[i] <= lane[i].dest;
                wb_data[i] <= use_csr[i] ? i_csr_rdata : lane[i].result;
            end
            dbg_pc[i]    <= wb_pc[i];
            dbg_wnum[i]  <= wb_dest[i];
            dbg_wdata[i] <= wb_data[i];
        end
    end

    assign o_rf_we1      = wb_valid[0];
    assign o_rf_waddr1   = wb_dest[0];
    assign o_rf_wdata1   = wb_data[0];
    assign o_rf_we2      = wb_valid[1];
    assign o_rf_waddr2   = wb_dest[1];
    assign o_rf_wdata2   = wb_data[1];

    assign o_dbg_a_wen   = dbg_wen[0];
    assign o_dbg_a_pc    = dbg_pc[0];
    assign o_dbg_a_wnum  = dbg_wnum[0];
    assign o_dbg_a_wdata = dbg_wdata[0];
    assign o_dbg_b_wen   = dbg_wen[1];
    assign o_dbg_b_pc    = dbg_pc[1];
    assign o_dbg_b_wnum  = dbg_wnum[1];
    assign o_dbg_b_wdata = dbg_wdata[1];

endmodule

`default_nettype wire

// ==== tests/tb_commit_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_commit_core;
    import commit_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 40;
    localparam int NUM_RANDOM      = 200;
    localparam int MARGIN_CYCLES   = 50;
    localparam commit_lane_t IDLE_LANE = '0;

    // What one trace port shows two cycles after its group.
    typedef struct packed {
        logic                  wen;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] wnum;
        logic [XLEN-1:0]       wdata;
    } trace_t;

    logic                  clk;
    logic                  reset;
    commit_lane_t          lane_a;
    commit_lane_t          lane_b;
    logic [REG_ADDR_W-1:0] rf_raddr1;
    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic                  flush;
    logic [XLEN-1:0]       redirect_pc;
    logic                  dbg_a_wen;
    logic [XLEN-1:0]       dbg_a_pc;
    logic [REG_ADDR_W-1:0] dbg_a_wnum;
    logic [XLEN-1:0]       dbg_a_wdata;
    logic                  dbg_b_wen;
    logic [XLEN-1:0]       dbg_b_pc;
    logic [REG_ADDR_W-1:0] dbg_b_wnum;
    logic [XLEN-1:0]       dbg_b_wdata;
    string                 test_name;
    integer                seed;

    // Reference model of the architectural state.
    logic [1:0]      m_plv;
    logic            m_ie;
    logic [1:0]      m_pplv;
    logic            m_pie;
    logic [5:0]      m_ecode;
    logic [XLEN-1:0] m_era;
    logic [XLEN-1:0] m_badv;
    logic [XLEN-1:0] m_eentry;
    logic [XLEN-1:0] m_save [4];
    logic [XLEN-1:0] m_regs [32];
    logic [31:0]     m_written;

    trace_t          exp_a, exp_b, s1_a, s1_b, s2_a, s2_b, got_a, got_b;
    logic            a_exc, b_exc, a_ok, b_ok, a_csr, b_csr;
    logic            exc_take, ertn_take, csr_do, exp_flush;
    logic [XLEN-1:0] exp_redirect, csr_old, csr_new, want_rd1, want_rd2;
    commit_lane_t    exc_lane, csr_lane;

    commit_core #(.NUM_REGS(32), .NUM_SAVE(4)) u_dut (
        .clk           (clk),
        .reset         (reset),
        .i_lane_a      (lane_a),
        .i_lane_b      (lane_b),
        .i_rf_raddr1   (rf_raddr1),
        .i_rf_raddr2   (rf_raddr2),
        .o_rf_rdata1   (rf_rdata1),
        .o_rf_rdata2   (rf_rdata2),
        .o_flush       (flush),
        .o_redirect_pc (redirect_pc),
        .o_dbg_a_wen   (dbg_a_wen),
        .o_dbg_a_pc    (dbg_a_pc),
        .o_dbg_a_wnum  (dbg_a_wnum),
        .o_dbg_a_wdata (dbg_a_wdata),
        .o_dbg_b_wen   (dbg_b_wen),
        .o_dbg_b_pc    (dbg_b_pc),
        .o_dbg_b_wnum  (dbg_b_wnum),
        .o_dbg_b_wdata (dbg_b_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always_comb begin
        a_exc     = lane_a.valid && lane_a.has_exc && lane_a.exc_type != ERTN;
        b_exc     = lane_b.valid && lane_b.has_exc && lane_b.exc_type != ERTN;
        a_ok      = lane_a.valid && !a_exc;
        b_ok      = lane_b.valid && !b_exc && !a_exc;   // An older exception kills lane b.
        exc_take  = a_exc || b_exc;
        exc_lane  = a_exc ? lane_a : lane_b;
        ertn_take = !exc_take && ((a_ok && lane_a.has_exc) || (b_ok && lane_b.has_exc));
        a_csr     = lane_a.valid && lane_a.is_csr;
        b_csr     = lane_b.valid && lane_b.is_csr && !a_csr;
        csr_lane  = a_csr ? lane_a : lane_b;
        csr_do    = !exc_take && (a_csr || b_csr);
        case (csr_lane.csr_addr)
            CRMD:    csr_old = {29'd0, m_ie, m_plv};
            PRMD:    csr_old = {29'd0, m_pie, m_pplv};
            ESTAT:   csr_old = {10'd0, m_ecode, 16'd0};
            ERA:     csr_old = m_era;
            BADV:    csr_old = m_badv;
            EENTRY:  csr_old = m_eentry;
            SAVE0, SAVE1, SAVE2, SAVE3: csr_old = m_save[2'(csr_lane.csr_addr - SAVE0)];
            default: csr_old = '0;
        endcase
        csr_new   = (csr_old & ~csr_lane.csr_mask) | (csr_lane.result & csr_lane.csr_mask);
        exp_flush = exc_take || ertn_take || csr_do;
        if (exc_take) begin
            exp_redirect = m_eentry;
        end else if (ertn_take) begin
            exp_redirect = m_era;
        end else begin
            exp_redirect = csr_lane.pc + 32'd4;
        end
        exp_a = '0;
        exp_b = '0;
        if (a_ok && lane_a.dest != '0) begin
            exp_a = {1'b1, lane_a.pc, lane_a.dest, ((csr_do && a_csr) ? csr_old : lane_a.result)};
        end
        if (b_ok && lane_b.dest != '0) begin
            exp_b = {1'b1, lane_b.pc, lane_b.dest, ((csr_do && b_csr) ? csr_old : lane_b.result)};
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            m_plv     <= 2'd0;
            m_ie      <= 1'b0;
            m_pplv    <= 2'd0;
            m_pie     <= 1'b0;
            m_ecode   <= '0;
            m_eentry  <= '0;
            m_written <= '0;
            s1_a      <= '0;
            s1_b      <= '0;
            s2_a      <= '0;
            s2_b      <= '0;
        end else begin
            // The register file sees a group one cycle after it retires.
            if (s1_a.wen) begin
                m_regs[s1_a.wnum]    <= s1_a.wdata;
                m_written[s1_a.wnum] <= 1'b1;
            end
            if (s1_b.wen) begin
                m_regs[s1_b.wnum]    <= s1_b.wdata;
                m_written[s1_b.wnum] <= 1'b1;
            end
            s1_a <= exp_a;
            s1_b <= exp_b;
            s2_a <= s1_a;
            s2_b <= s1_b;
            if (exc_take) begin
                m_pplv  <= m_plv;
                m_pie   <= m_ie;
                m_plv   <= 2'd0;
                m_ie    <= 1'b0;
                m_ecode <= exc_lane.exc_type;
                m_era   <= exc_lane.pc;
                if (exc_lane.exc_type == ALE) begin
                    m_badv <= exc_lane.result;
                end else if (exc_lane.exc_type == ADEF) begin
                    m_badv <= exc_lane.pc;
                end
            end else if (ertn_take) begin
                m_plv <= m_pplv;
                m_ie  <= m_pie;
            end else if (csr_do) begin
                case (csr_lane.csr_addr)
                    CRMD: begin
                        m_plv <= csr_new[1:0];
                        m_ie  <= csr_new[2];
                    end
                    PRMD: begin
                        m_pplv <= csr_new[1:0];
                        m_pie  <= csr_new[2];
                    end
                    ERA:     m_era    <= csr_new;
                    BADV:    m_badv   <= csr_new;
                    EENTRY:  m_eentry <= {csr_new[XLEN-1:6], 6'd0};
                    SAVE0, SAVE1, SAVE2, SAVE3: m_save[2'(csr_lane.csr_addr - SAVE0)] <= csr_new;
                    default: ;
                endcase
            end
        end
    end

    assign got_a    = dbg_a_wen ? {1'b1, dbg_a_pc, dbg_a_wnum, dbg_a_wdata} : '0;
    assign got_b    = dbg_b_wen ? {1'b1, dbg_b_pc, dbg_b_wnum, dbg_b_wdata} : '0;
    assign want_rd1 = (rf_raddr1 == '0) ? '0 : m_regs[rf_raddr1];
    assign want_rd2 = (rf_raddr2 == '0) ? '0 : m_regs[rf_raddr2];

    // Outputs settle after the rising edge, so the falling edge samples them.
    a_flush: assert property (@(negedge clk) disable iff (reset) flush == exp_flush)
        else report_mismatch("flush", 128'(exp_flush), 128'(flush));
    a_redirect: assert property (@(negedge clk) disable iff (reset)
        !exp_flush || redirect_pc == exp_redirect)
        else report_mismatch("redirect_pc", 128'(exp_redirect), 128'(redirect_pc));
    a_trace_a: assert property (@(negedge clk) disable iff (reset) got_a == s2_a)
        else report_mismatch("trace_a", 128'(s2_a), 128'(got_a));
    a_trace_b: assert property (@(negedge clk) disable iff (reset) got_b == s2_b)
        else report_mismatch("trace_b", 128'(s2_b), 128'(got_b));
    a_rdata1: assert property (@(negedge clk) disable iff (reset)
        (rf_raddr1 != '0 && !m_written[rf_raddr1]) || rf_rdata1 == want_rd1)
        else report_mismatch("rf_rdata1", 128'(want_rd1), 128'(rf_rdata1));
    a_rdata2: assert property (@(negedge clk) disable iff (reset)
        (rf_raddr2 != '0 && !m_written[rf_raddr2]) || rf_rdata2 == want_rd2)
        else report_mismatch("rf_rdata2", 128'(want_rd2), 128'(rf_rdata2));

    task automatic report_mismatch(input string what, input logic [127:0] want,
                                   input logic [127:0] got);
        $display("error %s %s expected %0h actual %0h", test_name, what, want, got);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic commit_lane_t alu_lane(input logic [XLEN-1:0] pc,
                                              input logic [REG_ADDR_W-1:0] dest,
                                              input logic [XLEN-1:0] value);
        commit_lane_t l;
        l        = '0;
        l.valid  = 1'b1;
        l.pc     = pc;
        l.dest   = dest;
        l.result = value;
        return l;
    endfunction

    function automatic commit_lane_t csr_op(input logic [XLEN-1:0] pc,
                                            input logic [REG_ADDR_W-1:0] dest,
                                            input csr_addr_e addr, input logic [XLEN-1:0] mask,
                                            input logic [XLEN-1:0] wdata);
        commit_lane_t l;
        l          = alu_lane(pc, dest, wdata);
        l.is_csr   = 1'b1;
        l.csr_addr = addr;
        l.csr_mask = mask;
        return l;
    endfunction

    function automatic commit_lane_t trap_op(input logic [XLEN-1:0] pc, input exc_type_e kind,
                                             input logic [XLEN-1:0] value);
        commit_lane_t l;
        l          = alu_lane(pc, 5'd0, value);
        l.has_exc  = 1'b1;
        l.exc_type = kind;
        return l;
    endfunction

    task automatic send_group(input commit_lane_t a, input commit_lane_t b);
        @(posedge clk);
        lane_a <= a;
        lane_b <= b;
    endtask

    task automatic read_back(input logic [REG_ADDR_W-1:0] r1, input logic [REG_ADDR_W-1:0] r2);
        send_group(IDLE_LANE, IDLE_LANE);
        rf_raddr1 <= r1;
        rf_raddr2 <= r2;
    endtask

    initial begin
        commit_lane_t la;
        commit_lane_t lb;
        logic [31:0]  r;
        seed      = 32'hb875ff6f;
        test_name = "reset";
        reset     <= 1'b1;
        lane_a    <= IDLE_LANE;
        lane_b    <= IDLE_LANE;
        rf_raddr1 <= '0;
        rf_raddr2 <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        test_name = "dual_wb";
        send_group(alu_lane(32'h1000, 5'd1, 32'h1111_0001),
                   alu_lane(32'h1004, 5'd2, 32'h2222_0002));
        send_group(alu_lane(32'h1008, 5'd3, 32'haaaa_0003),
                   alu_lane(32'h100c, 5'd3, 32'hbbbb_0003));
        send_group(alu_lane(32'h1010, 5'd0, 32'hdead_beef),
                   alu_lane(32'h1014, 5'd8, 32'h0808_0808));
        read_back(5'd1, 5'd2);
        read_back(5'd3, 5'd0);
        read_back(5'd8, 5'd3);

        test_name = "csr_save0";
        send_group(csr_op(32'h2000, 5'd0, SAVE0, 32'hffff_ffff, 32'h1234_5678), IDLE_LANE);
        send_group(alu_lane(32'h2004, 5'd5, 32'h5),
                   csr_op(32'h2008, 5'd6, SAVE0, 32'h0000_ffff, 32'haaaa_bbbb));
        send_group(csr_op(32'h200c, 5'd7, SAVE0, 32'h0, 32'h0), IDLE_LANE);
        read_back(5'd6, 5'd7);

        test_name = "exc_lane_a";
        send_group(csr_op(32'h3000, 5'd0, EENTRY, 32'hffff_ffff, 32'h1c00_8000), IDLE_LANE);
        send_group(csr_op(32'h3004, 5'd0, CRMD, 32'h7, 32'h7), IDLE_LANE); // PLV 3 with IE set.
        send_group(trap_op(32'h3008, ALE, 32'h0000_3001), alu_lane(32'h300c, 5'd8, 32'h8888_0008));
        send_group(csr_op(32'h1c00_8000, 5'd9, ERA, '0, '0), IDLE_LANE);
        send_group(csr_op(32'h1c00_8004, 5'd10, ESTAT, '0, '0), IDLE_LANE);
        send_group(csr_op(32'h1c00_8008, 5'd11, CRMD, '0, '0), IDLE_LANE);
        send_group(csr_op(32'h1c00_800c, 5'd12, BADV, '0, '0), IDLE_LANE);
        read_back(5'd8, 5'd9);

        test_name = "ertn";
        la      = trap_op(32'h1c00_8010, ERTN, 32'h0000_e0e0);
        la.dest = 5'd14;
        send_group(la, alu_lane(32'h1c00_8014, 5'd15, 32'h1515_1515));
        send_group(csr_op(32'h3008, 5'd16, CRMD, '0, '0), IDLE_LANE);
        send_group(csr_op(32'h300c, 5'd17, PRMD, '0, '0), IDLE_LANE);
        read_back(5'd14, 5'd16);

        test_name = "exc_lane_b";
        send_group(alu_lane(32'h4000, 5'd18, 32'h1818_1818), trap_op(32'h4004, SYS, 32'h0));
        send_group(csr_op(32'h1c00_8000, 5'd19, ERA, '0, '0), IDLE_LANE);
        send_group(trap_op(32'h6000, ADEF, 32'h0), IDLE_LANE);
        send_group(csr_op(32'h1c00_8000, 5'd20, BADV, '0, '0), IDLE_LANE);
        read_back(5'd18, 5'd19);

        test_name = "random";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r        = $random(seed);
            la       = alu_lane($random(seed), 5'($random(seed)), $random(seed));
            lb       = alu_lane($random(seed), 5'($random(seed)), $random(seed));
            la.valid = r[0] | r[1];
            lb.valid = r[2] | r[3];
            send_group(la, lb);
            rf_raddr1 <= r[8:4];
            rf_raddr2 <= r[13:9];
        end
        repeat (3) send_group(IDLE_LANE, IDLE_LANE);
        @(negedge clk);
        @(posedge clk);
        $display("No errors");
        $finish;
    end

    initial begin
        #((RESET_CYCLES + DIRECTED_CYCLES + NUM_RANDOM + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected number of cycles.");
        $display("Errors found");
        $fatal(1);
    end

endmodule

`default_nettype wire
